// File: verilog/obj_pkg.sv
// object layer shared definitions
// widths, table constants and the scanner state encoding

package obj_pkg;

    // object table layout
    localparam int obj_aw       = 9;   // 512 byte object RAM
    localparam int obj_bytes    = 5;   // y, attr, attr2, id, x
    localparam int scan_end     = 510; // first address past the last entry
    localparam int max_per_line = 32;

    // line buffer, two halves of 512 pixels
    localparam int ln_aw = 10;

    // object RAM byte address
    typedef logic [obj_aw-1:0] obj_addr_t;

    // CPU data and object RAM contents
    typedef logic [7:0] byte_t;

    // graphics ROM word address
    // {bank[3:0], id[7:0], row[3:0], half[1:0]}
    typedef logic [17:0] rom_addr_t;

    // four 4-bit pixels, stored as bit planes
    typedef logic [15:0] rom_word_t;

    // {palette, colour}
    typedef logic [7:0] pxl_t;

    // column inside one line buffer half
    typedef logic [ln_aw-2:0] posx_t;

    // colour index or palette
    typedef logic [3:0] nib_t;

    // table scanner
    typedef enum logic [2:0] {
        idle,       // waits for the end of blank
        read_y,
        read_attr,  // visibility decided here
        read_attr2,
        read_id,
        read_x,     // issues the copy strobe
        wait_copy   // drawer busy with the object
    } scan_state_t;

endpackage

// File: verilog/obj_ram.sv
// single port RAM with clock enable
// registered read, a write shows the new byte on q

`timescale 1ns/1ps

module obj_ram #(
    parameter int aw = obj_pkg::obj_aw
) (
    input  logic           clk,
    input  logic           cen,
    input  logic           we,
    input  logic [aw-1:0]  addr,
    input  obj_pkg::byte_t data,
    output obj_pkg::byte_t q
);

    obj_pkg::byte_t mem [0:(1<<aw)-1];

    always_ff @(posedge clk) begin
        if (cen) begin
            if (we) begin
                mem[addr] <= data;
                q         <= data; // write through
            end else begin
                q <= mem[addr];
            end
        end
    end

endmodule

// File: verilog/obj_fetch_if.sv
// scanner to drawer link
// one found object plus the copy handshake strobes

`timescale 1ns/1ps

interface obj_fetch_if;

    logic           copy;      // one clock, object fields valid
    logic           copy_done; // one clock, drawer finished
    obj_pkg::nib_t  y_row;     // row inside the object, vflip applied
    obj_pkg::byte_t id;        // low bit adjusted for tall objects
    obj_pkg::posx_t x;
    obj_pkg::nib_t  pal;
    obj_pkg::nib_t  bank;
    logic           hflip;
    logic           vflip;

    modport scan (output copy, y_row, id, x, pal, bank, hflip, vflip, input copy_done);

    modport draw (input copy, y_row, id, x, pal, bank, hflip, vflip, output copy_done);

endinterface

// File: verilog/obj_scan.sv
// object table scanner
// walks the table after each blank and hands visible objects to the drawer
// also muxes the object RAM address between CPU and scanner

`timescale 1ns/1ps

module obj_scan (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen_q,
    input  obj_pkg::obj_addr_t cpu_addr,
    input  logic               obj_cs,
    input  logic               cpu_wrn,
    input  obj_pkg::byte_t     cpu_dout,
    output obj_pkg::byte_t     obj_dout,
    input  obj_pkg::byte_t     vpos,
    input  logic               hbl,
    obj_fetch_if.scan          fetch
);

    obj_pkg::scan_state_t state;
    obj_pkg::obj_addr_t   scan;
    obj_pkg::obj_addr_t   next_scan;
    obj_pkg::obj_addr_t   ram_addr;
    logic [2:0]           offset;   // byte inside the entry
    logic [$clog2(obj_pkg::max_per_line)-1:0] obj_cnt;
    logic                 wait_mem; // RAM output not yet valid
    logic                 hbl_l;
    logic                 hbl_fall;
    logic                 scan_done;
    logic                 last_obj;
    logic                 visible;
    logic                 ram_we;
    logic                 ram_cen;
    logic [8:0]           sumy;
    obj_pkg::byte_t       scan_y;
    logic [4:0]           row_raw;
    logic                 tall;
    logic                 x_msb;

    assign hbl_fall  = hbl_l && !hbl;
    assign next_scan = scan + obj_pkg::obj_addr_t'(obj_pkg::obj_bytes);
    assign scan_done = next_scan == obj_pkg::obj_addr_t'(obj_pkg::scan_end);
    assign last_obj  = int'(obj_cnt) == obj_pkg::max_per_line - 1;
    assign sumy      = {1'b0, vpos} + {1'b0, scan_y};

    // obj_dout holds attr while this is looked at
    assign visible = obj_dout[7] && (&sumy[7:5]) && (sumy[8] == obj_dout[0])
                     && (sumy[4] || obj_dout[4]);

    // CPU owns the address while selected
    assign ram_addr = obj_cs ? cpu_addr : scan + {6'd0, offset};
    assign ram_we   = obj_cs && !cpu_wrn;
    assign ram_cen  = cen_q || !obj_cs; // scanner reads every clock

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= obj_pkg::idle;
            scan       <= '0;
            offset     <= '0;
            obj_cnt    <= '0;
            wait_mem   <= 1'b0;
            hbl_l      <= 1'b0;
            fetch.copy <= 1'b0;
        end else begin
            hbl_l      <= hbl;
            fetch.copy <= 1'b0;
            case (state)
                obj_pkg::idle: if (hbl_fall) begin
                    state    <= obj_pkg::read_y;
                    scan     <= '0;
                    offset   <= '0;
                    obj_cnt  <= '0;
                    wait_mem <= 1'b1;
                end
                obj_pkg::read_y: begin
                    wait_mem <= 1'b0;
                    if (!wait_mem) begin
                        offset   <= 3'd1;
                        wait_mem <= 1'b1;
                        state    <= obj_pkg::read_attr;
                    end
                end
                obj_pkg::read_attr: begin
                    wait_mem <= 1'b0;
                    if (wait_mem) begin
                        offset <= 3'd2; // prefetch attr2
                    end else if (visible) begin
                        offset <= 3'd3;
                        state  <= obj_pkg::read_attr2;
                    end else if (scan_done) begin
                        state <= obj_pkg::idle;
                    end else begin
                        scan     <= next_scan;
                        offset   <= '0;
                        wait_mem <= 1'b1;
                        state    <= obj_pkg::read_y;
                    end
                end
                obj_pkg::read_attr2: begin
                    offset <= 3'd4;
                    state  <= obj_pkg::read_id;
                end
                obj_pkg::read_id: state <= obj_pkg::read_x;
                obj_pkg::read_x: begin
                    fetch.copy <= 1'b1;
                    state      <= obj_pkg::wait_copy;
                end
                obj_pkg::wait_copy: if (fetch.copy_done) begin
                    if (scan_done || last_obj) begin
                        state <= obj_pkg::idle; // line is full or table ended
                    end else begin
                        scan     <= next_scan;
                        offset   <= '0;
                        obj_cnt  <= obj_cnt + 1'b1;
                        wait_mem <= 1'b1;
                        state    <= obj_pkg::read_y;
                    end
                end
                default: state <= obj_pkg::idle;
            endcase
        end
    end

    // object fields, stable from copy until copy_done
    always_ff @(posedge clk) begin
        case (state)
            obj_pkg::read_y: if (!wait_mem) scan_y <= obj_dout;
            obj_pkg::read_attr: if (!wait_mem) begin
                row_raw     <= sumy[4:0];
                tall        <= obj_dout[4];
                x_msb       <= obj_dout[1];
                fetch.vflip <= obj_dout[2];
                fetch.hflip <= ~obj_dout[3]; // attr bit is active low
            end
            obj_pkg::read_attr2: begin
                fetch.pal   <= obj_dout[7:4];
                fetch.bank  <= obj_dout[3:0];
                fetch.y_row <= row_raw[3:0] ^ {4{fetch.vflip}};
            end
            obj_pkg::read_id: fetch.id <= {obj_dout[7:1], obj_dout[0] ^ (tall & row_raw[4])};
            obj_pkg::read_x: fetch.x <= {x_msb, obj_dout};
            default: ;
        endcase
    end

    obj_ram #(.aw(obj_pkg::obj_aw)) u_obj_ram (
        .clk  (clk),
        .cen  (ram_cen),
        .we   (ram_we),
        .addr (ram_addr),
        .data (cpu_dout),
        .q    (obj_dout)
    );

    // copy only leaves read_x into wait_copy
    a_copy_slot: assert property (@(posedge clk) disable iff (rst)
        fetch.copy |-> ($past(state) == obj_pkg::read_x) && (state == obj_pkg::wait_copy));

endmodule

// File: verilog/obj_draw.sv
// object drawer
// fetches four ROM words per object row, reorders the bit planes
// into nibbles and shifts pixels out towards the line buffer

`timescale 1ns/1ps

module obj_draw (
    input  logic                clk,
    input  logic                rst,
    input  logic                pxl_cen,
    obj_fetch_if.draw           fetch,
    input  logic                line,
    output obj_pkg::rom_addr_t  rom_addr,
    input  obj_pkg::rom_word_t  rom_data,
    input  logic                rom_ok,
    output logic                pxl_we,
    output obj_pkg::posx_t      pxl_x,
    output obj_pkg::pxl_t       pxl_data
);

    logic               copying;
    logic [3:0]         cnt;      // {word, pixel in word}
    logic               ok_dly;
    logic               cen_l;    // readout slot in the line buffer
    logic               line_q;   // half shown when the object started
    logic               advance;
    logic               start;
    logic [1:0]         word_nx;
    obj_pkg::posx_t     posx;
    obj_pkg::rom_word_t shift;
    obj_pkg::rom_word_t src;
    obj_pkg::nib_t      col;

    // pixel k gets bits k+12, k+8, k+4 and k
    function automatic obj_pkg::rom_word_t planar_to_nib(input obj_pkg::rom_word_t w);
        obj_pkg::rom_word_t r;
        for (int k = 0; k < 4; k++) begin
            r[4*k +: 4] = {w[k+12], w[k+8], w[k+4], w[k]};
        end
        return r;
    endfunction

    assign start   = fetch.copy && !copying;
    assign advance = copying && ok_dly && rom_ok && !cen_l;
    assign word_nx = cnt[3:2] + 2'd1;
    assign src     = (cnt[1:0] == 2'd0) ? planar_to_nib(rom_data) : shift; // new word
    assign col     = fetch.hflip ? src[15:12] : src[3:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            copying         <= 1'b0;
            cnt             <= '0;
            ok_dly          <= 1'b0;
            cen_l           <= 1'b0;
            pxl_we          <= 1'b0;
            fetch.copy_done <= 1'b0;
        end else begin
            cen_l           <= pxl_cen;
            ok_dly          <= rom_ok;
            pxl_we          <= 1'b0;
            fetch.copy_done <= 1'b0;
            if (start) begin
                copying <= 1'b1;
                cnt     <= '0;
                ok_dly  <= 1'b0; // first word needs a fresh rom_ok
            end else if (advance) begin
                cnt <= cnt + 4'd1;
                // colour 0 is transparent
                // an object that outlived its line is dropped
                pxl_we <= (col != 4'd0) && (line == line_q);
                if (cnt == 4'hf) begin
                    copying         <= 1'b0;
                    fetch.copy_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            posx     <= fetch.x;
            line_q   <= line;
            rom_addr <= {fetch.bank, fetch.id, fetch.y_row, {2{fetch.hflip}}};
        end else if (advance) begin
            posx     <= posx + 9'd1;
            pxl_x    <= posx;
            pxl_data <= {fetch.pal, col};
            shift    <= fetch.hflip ? src << 4 : src >> 4;
            if (cnt[1:0] == 2'd0 && cnt[3:2] != 2'd3) begin
                // word latched, ask for the next half now
                rom_addr <= {fetch.bank, fetch.id, fetch.y_row, word_nx ^ {2{fetch.hflip}}};
            end
        end
    end

    // writes come one clock after a copying advance
    a_we_copying: assert property (@(posedge clk) disable iff (rst)
        pxl_we |-> $past(copying));

endmodule

// File: verilog/obj_line_buf.sv
// double line buffer
// one half is drawn while the other is read out, halves swap at end of blank
// clears the shown half during blank, readout beats drawer writes

`timescale 1ns/1ps

module obj_line_buf (
    input  logic           clk,
    input  logic           rst,
    input  logic           hbl,
    input  logic           pxl_cen,
    input  logic           pxl_we,
    input  obj_pkg::posx_t pxl_x,
    input  obj_pkg::pxl_t  pxl_data,
    output logic           line,
    output obj_pkg::pxl_t  obj_pxl
);

    logic                      hbl_l;
    logic                      cen_d1;    // read slot this clock
    logic [1:0]                rd_d;      // read pipeline
    logic                      hold_v;
    logic                      hold_load;
    logic                      ln_we;
    logic [obj_pkg::ln_aw-1:0] ln_addr;
    obj_pkg::byte_t            ln_data;
    obj_pkg::byte_t            ln_q;
    obj_pkg::posx_t            clr_cnt;
    obj_pkg::posx_t            rd_col;
    obj_pkg::posx_t            hold_x;
    obj_pkg::pxl_t             hold_data;

    // park a drawer write that lost the port
    assign hold_load = pxl_we && !hbl && (cen_d1 || hold_v);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line    <= 1'b0;
            hbl_l   <= 1'b0;
            cen_d1  <= 1'b0;
            rd_d    <= '0;
            hold_v  <= 1'b0;
            ln_we   <= 1'b0;
            clr_cnt <= '0;
            rd_col  <= '0;
            obj_pxl <= '0;
        end else begin
            hbl_l  <= hbl;
            cen_d1 <= pxl_cen && !hbl;
            rd_d   <= {rd_d[0], cen_d1 && !hbl};
            if (hbl_l && !hbl) line <= ~line;
            ln_we <= hbl || (!cen_d1 && (hold_v || pxl_we));
            if (hbl)
                hold_v <= 1'b0;
            else if (hold_load)
                hold_v <= 1'b1;
            else if (!cen_d1)
                hold_v <= 1'b0; // drained this clock
            clr_cnt <= hbl ? clr_cnt + 9'd1 : '0;
            if (hbl)
                rd_col <= '0;
            else if (cen_d1)
                rd_col <= rd_col + 9'd1;
            if (rd_d[1]) obj_pxl <= ln_q;
        end
    end

    // port contents, priority clear > read > held write > new write
    always_ff @(posedge clk) begin
        if (hbl) begin
            ln_addr <= {line, clr_cnt};
            ln_data <= '0;
        end else if (cen_d1) begin
            ln_addr <= {line, rd_col};
        end else if (hold_v) begin
            ln_addr <= {~line, hold_x};
            ln_data <= hold_data;
        end else begin
            ln_addr <= {~line, pxl_x};
            ln_data <= pxl_data;
        end
        if (hold_load) begin
            hold_x    <= pxl_x;
            hold_data <= pxl_data;
        end
    end

    obj_ram #(.aw(obj_pkg::ln_aw)) u_line_ram (
        .clk  (clk),
        .cen  (1'b1),
        .we   (ln_we),
        .addr (ln_addr),
        .data (ln_data),
        .q    (ln_q)
    );

    // drawing must finish inside the active line
    a_no_wr_blank: assert property (@(posedge clk) disable iff (rst)
        hbl |-> !pxl_we);

endmodule

// File: verilog/obj_layer.sv
// object layer top level
// scanner, drawer and line buffer with the CPU and ROM ports

`timescale 1ns/1ps

module obj_layer (
    input  logic               clk,
    input  logic               rst,
    input  logic               pxl_cen,
    input  logic               cen_q,
    // CPU access to the object RAM
    input  obj_pkg::obj_addr_t cpu_addr,
    input  logic               obj_cs,
    input  logic               cpu_wrn,
    input  obj_pkg::byte_t     cpu_dout,
    output obj_pkg::byte_t     obj_dout,
    // video timing
    input  obj_pkg::byte_t     vpos,
    input  logic               hbl,
    // graphics ROM
    output obj_pkg::rom_addr_t rom_addr,
    input  obj_pkg::rom_word_t rom_data,
    input  logic               rom_ok,
    output obj_pkg::pxl_t      obj_pxl
);

    logic           line;
    logic           pxl_we;
    obj_pkg::posx_t pxl_x;
    obj_pkg::pxl_t  pxl_data;

    obj_fetch_if fetch_if ();

    obj_scan u_scan (
        .clk      (clk),
        .rst      (rst),
        .cen_q    (cen_q),
        .cpu_addr (cpu_addr),
        .obj_cs   (obj_cs),
        .cpu_wrn  (cpu_wrn),
        .cpu_dout (cpu_dout),
        .obj_dout (obj_dout),
        .vpos     (vpos),
        .hbl      (hbl),
        .fetch    (fetch_if)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .fetch    (fetch_if),
        .line     (line),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .pxl_we   (pxl_we),
        .pxl_x    (pxl_x),
        .pxl_data (pxl_data)
    );

    obj_line_buf u_line_buf (
        .clk      (clk),
        .rst      (rst),
        .hbl      (hbl),
        .pxl_cen  (pxl_cen),
        .pxl_we   (pxl_we),
        .pxl_x    (pxl_x),
        .pxl_data (pxl_data),
        .line     (line),
        .obj_pxl  (obj_pxl)
    );

endmodule

// File: verification/obj_tb_clk.sv
// testbench clock and reset
// 10 ns clock, reset held for the first 16 cycles

`timescale 1ns/1ps

module obj_tb_clk (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk) rst = 1'b0;
    end

    always #5 clk = ~clk;

endmodule

// File: verification/obj_tb.sv
// object layer testbench
// table driven: loads the object RAM, draws one line, reads the next one
// back and compares every pixel with a reference line

`timescale 1ns/1ps

module obj_tb;

    localparam int n_tests = 6;
    localparam int line_clk = 2048; // 512 columns, pxl_cen every 4 clocks
    localparam int limit = n_tests * 4 * 2500;

    logic clk, rst, pxl_cen, cen_q, obj_cs, cpu_wrn, hbl;
    obj_pkg::obj_addr_t cpu_addr;
    obj_pkg::byte_t     cpu_dout, obj_dout, vpos;
    obj_pkg::rom_addr_t rom_addr;
    obj_pkg::rom_addr_t rom_addr_q;
    obj_pkg::rom_word_t rom_data = '0;
    logic               rom_ok = 1'b0;
    obj_pkg::pxl_t      obj_pxl;
    logic [31:0]        rng = 32'h249ff601;

    // stimulus table, one row per object or run of objects
    int             n_rows = 0;
    int             r_test [0:15], r_slot [0:15], r_cnt [0:15], r_x [0:15], r_step [0:15];
    obj_pkg::byte_t r_y [0:15], r_attr [0:15], r_attr2 [0:15], r_id [0:15];
    obj_pkg::byte_t t_vpos [0:n_tests-1];
    int             t_vis [0:n_tests-1];

    obj_pkg::byte_t tab [0:509];      // image of the object RAM
    obj_pkg::pxl_t  ref_line [0:511];
    int             errors = 0;
    int             checks = 0;
    int             cycles = 0;

    obj_tb_clk u_clk (.clk(clk), .rst(rst));

    obj_layer dut0 (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .cen_q(cen_q),
        .cpu_addr(cpu_addr), .obj_cs(obj_cs), .cpu_wrn(cpu_wrn),
        .cpu_dout(cpu_dout), .obj_dout(obj_dout), .vpos(vpos), .hbl(hbl),
        .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok), .obj_pxl(obj_pxl)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic obj_pkg::rom_word_t rom_word(input obj_pkg::rom_addr_t a);
        logic [31:0] v;
        v = xorshift({14'd0, a});
        return v[15:0];
    endfunction

    // ROM model, one clock latency, random rom_ok drops
    always @(negedge clk) begin
        rom_addr_q <= rom_addr;
        rom_data   <= rom_word(rom_addr_q);
        rng        <= xorshift(rng);
        rom_ok     <= rng[2:0] != 3'd0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic add_row(input int t, slot, cnt, input obj_pkg::byte_t y, attr, attr2, id,
                           input int x, step);
        r_test[n_rows] = t;
        r_slot[n_rows] = slot;
        r_cnt[n_rows]  = cnt;
        r_y[n_rows]    = y;
        r_attr[n_rows] = attr;
        r_attr2[n_rows] = attr2;
        r_id[n_rows]   = id;
        r_x[n_rows]    = x;
        r_step[n_rows] = step;
        n_rows++;
    endtask

    task automatic check_byte(input int addr, input obj_pkg::byte_t got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: obj_dout at %0d is %h, expected %h", $time, addr, got, exp);
        end
    endtask

    task automatic check_pxl(input int col, input obj_pkg::pxl_t got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: pixel %0d is %h, expected %h", $time, col, got, exp);
        end
    endtask

    // reference line from the visibility and drawing rules
    task automatic build_ref(input obj_pkg::byte_t v, output int nvis);
        logic [8:0]         sum;
        logic               hf;
        logic [3:0]         row, c;
        logic [1:0]         half;
        obj_pkg::byte_t     y, at, at2, idv;
        logic [8:0]         xx;
        obj_pkg::rom_word_t d;
        int                 s, p, k;
        nvis = 0;
        for (p = 0; p < 512; p++) ref_line[p] = '0;
        for (s = 0; s < 102; s++) begin
            y   = tab[s*5];
            at  = tab[s*5+1];
            at2 = tab[s*5+2];
            sum = {1'b0, v} + {1'b0, y};
            // entries past the per line cap are never drawn
            if (at[7] && (&sum[7:5]) && sum[8] == at[0] && (sum[4] || at[4])
                && nvis < obj_pkg::max_per_line) begin
                nvis++;
                hf  = ~at[3];
                row = sum[3:0] ^ {4{at[2]}};
                idv = tab[s*5+3];
                idv[0] = idv[0] ^ (at[4] & sum[4]);
                xx  = {at[1], tab[s*5+4]};
                for (p = 0; p < 16; p++) begin
                    k    = hf ? 3 - p % 4 : p % 4;
                    half = hf ? 2'(3 - p / 4) : 2'(p / 4);
                    d    = rom_word({at2[3:0], idv, row, half});
                    c    = {d[k+12], d[k+8], d[k+4], d[k]};
                    if (c != 4'd0) ref_line[(int'(xx) + p) % 512] = {at2[7:4], c};
                end
            end
        end
    endtask

    // one active line, then blank again
    task automatic run_line(input bit check);
        int c;
        for (c = 0; c <= line_clk; c++) begin
            @(negedge clk);
            if (check && c >= 4) check_pxl(c / 4 - 1, obj_pxl, ref_line[c / 4 - 1]);
            hbl     = 1'b0;
            pxl_cen = (c % 4 == 0) && (c < line_clk);
        end
        @(negedge clk);
        pxl_cen = 1'b0;
        hbl     = 1'b1;
        repeat (519) @(negedge clk);
    endtask

    initial begin
        int t, i, j, a, nvis, err0;
        pxl_cen = 1'b0;
        cen_q = 1'b1;
        cpu_addr = '0;
        obj_cs = 1'b0;
        cpu_wrn = 1'b1;
        cpu_dout = '0;
        vpos = '0;
        hbl = 1'b1;
        t_vpos = '{8'h80, 8'h80, 8'h80, 8'hff, 8'h80, 8'h20};
        t_vis  = '{1, 3, 3, 3, 32, 0};
        add_row(0, 0, 1, 8'h75, 8'h88, 8'h35, 8'h12, 40, 0);
        add_row(1, 0, 1, 8'h75, 8'h80, 8'h35, 8'h12, 40, 0);  // hflip
        add_row(1, 1, 1, 8'h75, 8'h8c, 8'h47, 8'h12, 100, 0); // vflip
        add_row(1, 2, 1, 8'h75, 8'h84, 8'h47, 8'h12, 200, 0); // both
        add_row(2, 0, 1, 8'h75, 8'h08, 8'h35, 8'h21, 10, 0);  // disabled
        add_row(2, 1, 1, 8'h50, 8'h88, 8'h35, 8'h21, 40, 0);  // out of zone
        add_row(2, 2, 1, 8'h75, 8'h89, 8'h35, 8'h21, 70, 0);  // y msb differs
        add_row(2, 3, 1, 8'h60, 8'h98, 8'h35, 8'h21, 100, 0); // tall, upper half
        add_row(2, 4, 1, 8'h75, 8'h98, 8'h52, 8'h21, 140, 0); // tall, lower half
        add_row(2, 5, 1, 8'h75, 8'h8a, 8'h35, 8'h21, 32, 0);  // x msb
        add_row(2, 6, 1, 8'h65, 8'h88, 8'h35, 8'h21, 400, 0);
        add_row(3, 0, 1, 8'hf5, 8'h89, 8'h16, 8'h33, 50, 0);  // overlaps
        add_row(3, 1, 1, 8'hf5, 8'h89, 8'h2b, 8'h34, 58, 0);
        add_row(3, 2, 1, 8'hf5, 8'h8d, 8'he7, 8'h35, 60, 0);
        add_row(4, 10, 40, 8'h75, 8'h88, 8'h49, 8'h40, 0, 12); // more than 32
        @(negedge clk);
        while (rst) @(negedge clk);
        for (t = 0; t < n_tests; t++) begin
            err0 = errors;
            for (a = 0; a < 510; a++) tab[a] = '0;
            for (i = 0; i < n_rows; i++) begin
                if (r_test[i] == t) begin
                    for (j = 0; j < r_cnt[i]; j++) begin
                        a = (r_slot[i] + j) * obj_pkg::obj_bytes;
                        tab[a]   = r_y[i];
                        tab[a+1] = r_attr[i];
                        tab[a+2] = r_attr2[i];
                        tab[a+3] = r_id[i] + 8'(j);
                        tab[a+4] = 8'(r_x[i] + j * r_step[i]);
                        if (r_x[i] + j * r_step[i] > 255) tab[a+1][1] = 1'b1;
                    end
                end
            end
            for (a = 0; a < 510; a++) begin
                @(negedge clk);
                obj_cs = 1'b1;
                cpu_wrn = 1'b0;
                cpu_addr = 9'(a);
                cpu_dout = tab[a];
            end
            for (a = 0; a < 510; a++) begin
                @(negedge clk);
                cpu_wrn = 1'b1;
                cpu_addr = 9'(a);
                @(negedge clk);
                check_byte(a, obj_dout, tab[a]);
            end
            obj_cs = 1'b0;
            vpos = t_vpos[t];
            build_ref(t_vpos[t], nvis);
            if (nvis != t_vis[t]) begin
                errors++;
                $display("test %0d table lists %0d visible objects, rules give %0d", t,
                         t_vis[t], nvis);
            end
            run_line(1'b0); // draw
            run_line(1'b1); // read out and compare
            $display("test %0d vpos %h visible %0d errors %0d", t, t_vpos[t], nvis,
                     errors - err0);
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
verilog/obj_pkg.sv
verilog/obj_ram.sv
verilog/obj_fetch_if.sv
verilog/obj_scan.sv
verilog/obj_draw.sv
verilog/obj_line_buf.sv
verilog/obj_layer.sv
verification/obj_tb_clk.sv
verification/obj_tb.sv

// File: Makefile
# Verilator build of the object layer testbench

SIM = obj_dir/Vobj_tb

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): compile.f verilog/*.sv verification/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module obj_tb -f compile.f

run: $(SIM)
	./$(SIM) | awk '{ print } /TEST RESULT: PASS/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
